// ==== src/stoch_pkg.sv ====
// Stochastic integrator shared package: widths, limits, LFSR constants, bundles and opcodes
package stoch_pkg;

    // Probability and counter word
    localparam int VALUE_W = 9;
    localparam logic [VALUE_W-1:0] VALUE_MAX = 9'd511; // Upper saturation
    localparam logic [VALUE_W-1:0] VALUE_MIN = 9'd0;   // Lower saturation
    localparam int NUM_INTEG = 3;                      // Integrators in the cascade

    // Serial framing, 9 data slots then one dummy slot
    localparam int FRAME_LEN = 10;
    localparam int SLOT_W    = $clog2(FRAME_LEN);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(FRAME_LEN - 1);

    // Output sampling period
    localparam int SAMPLE_INTERVAL = 16;
    localparam int INTERVAL_W      = $clog2(SAMPLE_INTERVAL);
    localparam logic [INTERVAL_W-1:0] LAST_INTERVAL = INTERVAL_W'(SAMPLE_INTERVAL - 1);

    // Fibonacci LFSR
    localparam int LFSR_W     = 31;
    localparam int LFSR_TAP_A = 27;
    localparam int LFSR_TAP_B = 30;                    // Feedback is TAP_A xor TAP_B
    localparam logic [LFSR_W-1:0] LFSR_SEED = 31'd134995;

    typedef logic [VALUE_W-1:0] value_t;
    typedef logic [LFSR_W-1:0]  lfsr_t;
    typedef logic [SLOT_W-1:0]  slot_t;

    typedef struct packed {
        logic a;
        logic b;
    } serial_in_t;

    typedef struct packed {
        value_t a;                                     // Increment probability
        value_t b;                                     // Shared decrement probability
    } input_values_t;

    // Random words, one per comparator
    typedef struct packed {
        value_t in_a;
        value_t in_b;
        value_t int_a;
        value_t int_b;
        value_t int_c;
    } rand_slices_t;

    typedef struct packed {
        value_t a;                                     // t
        value_t b;                                     // t^2/2
        value_t c;                                     // t^3/6
    } integ_values_t;

    typedef struct packed {
        logic a;
        logic b;
        logic c;
    } serial_out_t;

    typedef enum logic [1:0] {
        HOLD = 2'd0,
        UP   = 2'd1,
        DOWN = 2'd2
    } count_op_e;

endpackage

// ==== src/serial_value_rx.sv ====
// Serial input receiver, turns two 10-slot serial frames into the a and b probabilities
`timescale 1ns/1ps

module serial_value_rx
    import stoch_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,      // Asynchronous, active high
    input  serial_in_t    ser_in,
    output input_values_t in_values
);

    slot_t         slot_q;            // Position inside the current frame
    input_values_t shift_q;           // Words being assembled

    // Free-running frame slot, 0 to 9 from reset
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            slot_q <= '0;
        end else if (slot_q == LAST_SLOT) begin
            slot_q <= '0;
        end else begin
            slot_q <= slot_q + 1'b1;
        end
    end

    // Data enters at the MSB and walks down, so slot j lands in bit j after 9 shifts
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            shift_q <= '0;
        end else if (slot_q != LAST_SLOT) begin
            shift_q.a <= {ser_in.a, shift_q.a[VALUE_W-1:1]};
            shift_q.b <= {ser_in.b, shift_q.b[VALUE_W-1:1]};
        end
        // Dummy slot, input bit dropped
    end

    // Held values update once per frame
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            in_values <= '0;                    // Both probabilities start at zero
        end else if (slot_q == LAST_SLOT) begin
            in_values <= shift_q;               // Completed frame
        end
    end

endmodule

// ==== src/lfsr_source.sv ====
// Free-running 31-bit Fibonacci LFSR that supplies scrambled 9-bit random words
`timescale 1ns/1ps

module lfsr_source
    import stoch_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,       // Asynchronous, active high
    output rand_slices_t slices
);

    lfsr_t lfsr_q;
    logic  feedback;

    assign feedback = lfsr_q[LFSR_TAP_A] ^ lfsr_q[LFSR_TAP_B];

    // Shift up one bit per cycle, new bit enters at 0
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            lfsr_q <= LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[LFSR_W-2:0], feedback};
        end
    end

    // Each comparator gets its own bit mix
    // Keeps the input and feedback streams from lining up
    always_comb begin
        slices.in_a  = lfsr_q[8:0];
        slices.in_b  = {lfsr_q[5:0], lfsr_q[18:16]};
        slices.int_a = lfsr_q[30:22];                   // Top of register
        slices.int_b = {lfsr_q[15:13], lfsr_q[6:1]};
        slices.int_c = {lfsr_q[24:19], lfsr_q[14:12]};
    end

endmodule

// ==== src/integrator_chain.sv ====
// Stochastic integrator cascade: number generators and three saturating up/down counters
`timescale 1ns/1ps

module integrator_chain
    import stoch_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,        // Asynchronous, active high
    input  input_values_t in_values,
    input  rand_slices_t  slices,
    output integ_values_t integ_values,
    output logic          sn_bit_c      // Third integrator bitstream
);

    integ_values_t integ_q;

    // Stochastic bits, 1 when value beats the random word
    logic sn_in_a;
    logic sn_in_b;
    logic sn_a;
    logic sn_b;
    logic sn_c;

    count_op_e op_a;
    count_op_e op_b;
    count_op_e op_c;

    // Up alone counts up, down alone counts down, anything else holds
    function automatic count_op_e decode_op(input logic up, input logic down);
        count_op_e op;
        case ({up, down})
            2'b10:   op = UP;
            2'b01:   op = DOWN;
            default: op = HOLD;                 // Both or neither cancel
        endcase
        return op;
    endfunction

    // One step with clamping at both ends
    function automatic value_t sat_step(input value_t value, input count_op_e op);
        value_t next;
        next = value;
        case (op)
            UP: begin
                if (value != VALUE_MAX) begin
                    next = value + 1'b1;
                end
            end
            DOWN: begin
                if (value != VALUE_MIN) begin
                    next = value - 1'b1;
                end
            end
            default: next = value;
        endcase
        return next;
    endfunction

    // Input streams
    assign sn_in_a = (in_values.a > slices.in_a);
    assign sn_in_b = (in_values.b > slices.in_b);       // Shared decrement

    // Feedback streams from the counter registers
    assign sn_a = (integ_q.a > slices.int_a);
    assign sn_b = (integ_q.b > slices.int_b);
    assign sn_c = (integ_q.c > slices.int_c);

    // Cascade: each stage integrates the stream of the one before
    assign op_a = decode_op(sn_in_a, sn_in_b);
    assign op_b = decode_op(sn_a, sn_in_b);
    assign op_c = decode_op(sn_b, sn_in_b);

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            integ_q <= '0;
        end else begin
            integ_q.a <= sat_step(integ_q.a, op_a);
            integ_q.b <= sat_step(integ_q.b, op_b);
            integ_q.c <= sat_step(integ_q.c, op_c);
        end
    end

    assign integ_values = integ_q;
    assign sn_bit_c     = sn_c;                 // Straight off the last comparator

endmodule

// ==== src/sample_serializer.sv ====
// Output side: samples the integrators every 16 cycles and sends each as a 10-bit serial frame
`timescale 1ns/1ps

module sample_serializer
    import stoch_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,        // Asynchronous, active high
    input  integ_values_t integ_values,
    output serial_out_t   ser_out
);

    logic [INTERVAL_W-1:0] interval_q;  // Cycle position inside the sample period
    slot_t                 slot_q;      // Shared frame slot for all three lanes
    integ_values_t         sample_q;

    // Lane view of the sample, lane 2 is integrator a
    logic [NUM_INTEG-1:0][VALUE_W-1:0] sample_words;
    logic [NUM_INTEG-1:0][VALUE_W-2:0] shift_q;   // Bits 8..1 waiting to go out
    logic [NUM_INTEG-1:0]              out_q;

    assign sample_words = sample_q;

    // Sample strobe at every interval wrap
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            interval_q <= '0;
        end else if (interval_q == LAST_INTERVAL) begin
            interval_q <= '0;
        end else begin
            interval_q <= interval_q + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            sample_q <= '0;
        end else if (interval_q == '0) begin
            sample_q <= integ_values;           // Snapshot of the live counters
        end
    end

    // Frame slot, runs 0 to 9 in step with the input side
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            slot_q <= '0;
        end else if (slot_q == LAST_SLOT) begin
            slot_q <= '0;
        end else begin
            slot_q <= slot_q + 1'b1;
        end
    end

    // LSB first, then the trailing zero
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            shift_q <= '0;
            out_q   <= '0;
        end else begin
            for (int i = 0; i < NUM_INTEG; i++) begin
                if (slot_q == '0) begin
                    out_q[i]   <= sample_words[i][0];                 // Bit 0 goes now
                    shift_q[i] <= sample_words[i][VALUE_W-1:1];       // Rest is latched
                end else if (slot_q == LAST_SLOT) begin
                    out_q[i] <= 1'b0;                                 // Frame terminator
                end else begin
                    out_q[i]   <= shift_q[i][0];
                    shift_q[i] <= shift_q[i] >> 1;
                end
            end
        end
    end

    assign ser_out = out_q;

endmodule

// ==== src/stoch_integrator_top.sv ====
// Stochastic Euler integrator top level, serial probabilities in, serial integrals out
`timescale 1ns/1ps

module stoch_integrator_top
    import stoch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,          // Asynchronous, active high
    input  serial_in_t  ser_in,         // Serial a and b probability frames
    output serial_out_t ser_out,        // Serial frames of t, t^2/2, t^3/6
    output logic        sn_bit_c        // Raw stream of the third integrator
);

    input_values_t in_values;
    rand_slices_t  slices;
    integ_values_t integ_values;

    // Input side
    serial_value_rx rx_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ser_in    (ser_in),
        .in_values (in_values)
    );

    // Shared randomness
    lfsr_source lfsr_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .slices (slices)
    );

    // Integrator cascade
    integrator_chain chain_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_values    (in_values),
        .slices       (slices),
        .integ_values (integ_values),
        .sn_bit_c     (sn_bit_c)
    );

    // Output side
    sample_serializer ser_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .integ_values (integ_values),
        .ser_out      (ser_out)
    );

endmodule

// ==== dv/stoch_integrator_assertions.sv ====
// Concurrent checks on output framing, input update timing and integrator step size
`timescale 1ns/1ps

module stoch_integrator_assertions
    import stoch_pkg::*;
(
    input logic          clk,
    input logic          rst_n,
    input serial_out_t   ser_out,
    input input_values_t in_values,
    input integ_values_t integ_values
);

    slot_t slot_q;                      // Slot of the edge being sampled

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            slot_q <= '0;
        end else if (slot_q == LAST_SLOT) begin
            slot_q <= '0;
        end else begin
            slot_q <= slot_q + slot_t'(1);
        end
    end

    // Counters move by at most one per clock, no wrap
    function automatic logic small_step(input value_t now, input value_t prev);
        int diff;
        diff = int'(now) - int'(prev);
        return (diff >= -1) && (diff <= 1);
    endfunction

    // Dummy slot output is seen at the following slot 0 edge
    frame_end_zero: assert property (@(posedge clk) disable iff (rst_n)
        (slot_q == '0) |-> (ser_out == '0))
        else $error("Serial output not zero in the dummy slot");

    integ_step: assert property (@(posedge clk) disable iff (rst_n)
        small_step(integ_values.a, $past(integ_values.a)) &&
        small_step(integ_values.b, $past(integ_values.b)) &&
        small_step(integ_values.c, $past(integ_values.c)))
        else $error("Integrator moved by more than one step");

    // Update at slot 9 becomes visible at the next slot 0 sample
    input_update: assert property (@(posedge clk) disable iff (rst_n)
        (in_values != $past(in_values)) |-> (slot_q == '0))
        else $error("Input values changed outside the dummy slot");

endmodule

bind stoch_integrator_top stoch_integrator_assertions assertions_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .ser_out      (ser_out),
    .in_values    (in_values),
    .integ_values (integ_values)
);

// ==== dv/tb_stoch_integrator.sv ====
// Testbench for the stochastic integrator that checks file vectors against a cycle-exact model
`timescale 1ns/1ps

module tb_stoch_integrator
    import stoch_pkg::*;
();

    logic        clk;
    logic        rst_n;
    serial_in_t  ser_in;
    serial_out_t ser_out;
    logic        sn_bit_c;

    // Reference model state
    lfsr_t         m_lfsr;
    input_values_t m_acc;               // Frame being assembled
    input_values_t m_in;
    integ_values_t m_int;
    integ_values_t m_sample;
    integ_values_t m_frame;             // Sample latched at output slot 0
    serial_out_t   m_out;
    int            edge_cnt;            // Edges since reset release

    // Driver and decoder state
    value_t        cur_a;
    value_t        cur_b;
    integ_values_t dec_word;
    integ_values_t prev_word;
    logic          rising;              // a full and b zero
    logic          falling;             // a zero and b full
    int            vec_frames;
    integer        seed = 56;

    stoch_integrator_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ser_in   (ser_in),
        .ser_out  (ser_out),
        .sn_bit_c (sn_bit_c)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic check_serial(input serial_out_t got, input serial_out_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_word(input value_t got, input value_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    // Saturating up/down step
    function automatic value_t next_count(input value_t v, input logic up, input logic down);
        if (up && !down && v != VALUE_MAX) return v + 9'd1;
        if (down && !up && v != VALUE_MIN) return v - 9'd1;
        return v;
    endfunction

    function automatic logic model_sn_c();
        value_t r_c;
        r_c = {m_lfsr[24:19], m_lfsr[14:12]};
        return m_int.c > r_c;
    endfunction

    // One rising edge of the whole design from pre-edge state
    task automatic step_model(input serial_in_t sin);
        value_t        r_in_a;
        value_t        r_in_b;
        value_t        r_a;
        value_t        r_b;
        logic          s_in_a;
        logic          s_in_b;
        logic          s_a;
        logic          s_b;
        int            slot;
        integ_values_t old_int;
        integ_values_t old_sample;
        r_in_a = m_lfsr[8:0];
        r_in_b = {m_lfsr[5:0], m_lfsr[18:16]};
        r_a    = m_lfsr[30:22];
        r_b    = {m_lfsr[15:13], m_lfsr[6:1]};
        s_in_a = m_in.a > r_in_a;
        s_in_b = m_in.b > r_in_b;
        s_a    = m_int.a > r_a;
        s_b    = m_int.b > r_b;
        old_int    = m_int;
        old_sample = m_sample;
        slot       = edge_cnt % FRAME_LEN;
        m_int.a = next_count(old_int.a, s_in_a, s_in_b);
        m_int.b = next_count(old_int.b, s_a, s_in_b);
        m_int.c = next_count(old_int.c, s_b, s_in_b);
        if (slot < FRAME_LEN - 1) begin
            m_acc.a[slot] = sin.a;      // Slot j lands in bit j
            m_acc.b[slot] = sin.b;
        end else begin
            m_in = m_acc;
        end
        if (edge_cnt % SAMPLE_INTERVAL == 0) m_sample = old_int;
        if (slot == 0) begin
            m_frame = old_sample;
            m_out   = {old_sample.a[0], old_sample.b[0], old_sample.c[0]};
        end else if (slot == FRAME_LEN - 1) begin
            m_out = '0;                 // Trailing zero
        end else begin
            m_out = {m_frame.a[slot], m_frame.b[slot], m_frame.c[slot]};
        end
        m_lfsr = {m_lfsr[LFSR_W-2:0], m_lfsr[27] ^ m_lfsr[30]};
        edge_cnt++;
    endtask

    function automatic serial_in_t frame_bits(input int slot);
        serial_in_t s;
        s = '0;
        if (slot < FRAME_LEN - 1) begin
            s.a = cur_a[slot];
            s.b = cur_b[slot];
        end
        return s;
    endfunction

    // Collects LSB-first frames and checks them once complete
    task automatic decode_output(input int slot);
        int da;
        if (slot < FRAME_LEN - 1) begin
            dec_word.a[slot] = ser_out.a;
            dec_word.b[slot] = ser_out.b;
            dec_word.c[slot] = ser_out.c;
        end else begin
            check_serial(ser_out, serial_out_t'(0), "frame end bit");
            check_word(dec_word.a, m_frame.a, "lane a word");
            check_word(dec_word.b, m_frame.b, "lane b word");
            check_word(dec_word.c, m_frame.c, "lane c word");
            da = int'(dec_word.a) - int'(prev_word.a);
            if (vec_frames >= 5 && rising && da < 0) begin
                fail_run($sformatf("Error at %0t ns: lane a fell while rising", $time));
            end
            if (vec_frames >= 5 && falling && da > 0) begin
                fail_run($sformatf("Error at %0t ns: lane a rose while falling", $time));
            end
            prev_word = dec_word;
            vec_frames++;
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        step_model(ser_in);             // Same bit the DUT samples now
        ser_in <= frame_bits(edge_cnt % FRAME_LEN);
        @(negedge clk);
        check_serial(ser_out, m_out, "ser_out");
        check_bit(sn_bit_c, model_sn_c(), "sn_bit_c");
        decode_output((edge_cnt - 1) % FRAME_LEN);
    endtask

    // Stops with the dummy bit on the line so the next frame starts clean
    task automatic align_to_frame(input logic expect_idle);
        int waited;
        waited = 0;
        while (edge_cnt % FRAME_LEN != FRAME_LEN - 1) begin
            if (waited > 2 * FRAME_LEN) begin
                fail_run("Timed out waiting for frame alignment");
            end else begin
                run_cycle();
                waited++;
                if (expect_idle) begin
                    check_serial(ser_out, serial_out_t'(0), "idle ser_out");
                    check_bit(sn_bit_c, 1'b0, "idle sn_bit_c");
                end
            end
        end
    endtask

    task automatic run_vector(input value_t a, input value_t b, input int frames,
                              input value_t lo, input value_t hi, input logic bounded);
        align_to_frame(1'b0);
        cur_a      = a;
        cur_b      = b;
        rising     = (a == VALUE_MAX) && (b == VALUE_MIN);
        falling    = (a == VALUE_MIN) && (b == VALUE_MAX);
        vec_frames = 0;
        for (int i = 0; i < frames * FRAME_LEN; i++) begin
            run_cycle();
        end
        if (bounded && (prev_word.a < lo || prev_word.a > hi)) begin
            fail_run($sformatf("Error at %0t ns: lane a %0d outside %0d to %0d",
                               $time, prev_word.a, lo, hi));
        end
    endtask

    initial begin
        int    fd;
        int    n_dir;
        int    a_val;
        int    b_val;
        int    frames;
        int    lo;
        int    hi;
        string line;
        rst_n     = 1'b1;               // Reset is active high
        ser_in    = '0;
        cur_a     = '0;
        cur_b     = '0;
        m_lfsr    = LFSR_SEED;
        m_acc     = '0;
        m_in      = '0;
        m_int     = '0;
        m_sample  = '0;
        m_frame   = '0;
        m_out     = '0;
        edge_cnt  = 0;
        dec_word  = '0;
        prev_word = '0;
        rising    = 1'b0;
        falling   = 1'b0;
        n_dir     = 0;
        repeat (4) @(posedge clk);
        rst_n  <= 1'b0;
        ser_in <= '0;
        align_to_frame(1'b1);
        fd = $fopen("dv/integrator_tests.txt", "r");
        if (fd == 0) fail_run("Could not open dv/integrator_tests.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) != "#" &&
                $sscanf(line, "%d %d %d %d %d", a_val, b_val, frames, lo, hi) == 5) begin
                run_vector(value_t'(a_val), value_t'(b_val), frames,
                           value_t'(lo), value_t'(hi), 1'b1);
                n_dir++;
                // Random pair before the next directed one
                run_vector(value_t'($random(seed)), value_t'($random(seed)), 8,
                           '0, '0, 1'b0);
            end
        end
        $fclose(fd);
        if (n_dir == 0) begin
            fail_run("No vectors found in the data file");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== list.f ====
src/stoch_pkg.sv
src/serial_value_rx.sv
src/lfsr_source.sv
src/integrator_chain.sv
src/sample_serializer.sv
src/stoch_integrator_top.sv
dv/stoch_integrator_assertions.sv
dv/tb_stoch_integrator.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_stoch_integrator -f list.f
	./obj_dir/Vtb_stoch_integrator | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

// ==== dv/integrator_tests.txt ====
# a b frames lo hi, decimal
# lo and hi bound the last decoded integrator a word of the run
0 0 8 0 0
511 0 80 511 511
0 511 80 0 0
384 0 120 511 511
0 384 120 0 0
256 0 150 511 511
0 256 150 0 0
128 0 300 511 511
0 128 300 0 0
500 20 100 450 511
20 500 100 0 60
300 100 200 440 511
100 300 200 0 64
256 256 60 0 511
511 511 40 0 511
1 0 40 0 511
0 1 40 0 511
7 3 60 0 511
511 0 80 511 511
200 200 50 0 511
0 511 80 0 0
450 0 120 511 511
0 450 120 0 0
64 32 100 0 511
511 0 100 511 511
0 511 100 0 0
